// File: Bender.yml
package:
  name: blit_addr

sources:
  - include_dirs:
      - common
    files:
      - common/blit_reg_pkg.sv
      - common/blit_seq_pkg.sv
      - address/address_regs.sv
      - address/address_pointer.sv
      - address/address_gen.sv
      - verilog/blit_sequencer.sv
      - verilog/blit_counter.sv
      - verilog/blit_addr_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/blit_addr_checker.sv
      - tests/tb_blit_addr.sv

// File: address/address_gen.sv
// Linear byte address for A1 and A2 and the A1 clip compare
// Pure combinational, no pitch or Z offset
// Pixel size above 2 is not checked and simply shifts further
`timescale 1ns/1ps
`include "blit_macros.svh"

module address_gen (
	input  logic [`BLIT_COORD_W-1:0]  a1_x,
	input  logic [`BLIT_COORD_W-1:0]  a1_y,
	input  logic [`BLIT_COORD_W-1:0]  a2_x,
	input  logic [`BLIT_COORD_W-1:0]  a2_y,
	input  logic [`BLIT_BASE_W-1:0]   a1_base,
	input  logic [`BLIT_BASE_W-1:0]   a2_base,
	input  logic [`BLIT_FLAGS_W-1:0]  a1_flags,
	input  logic [`BLIT_FLAGS_W-1:0]  a2_flags,
	input  logic [`BLIT_WIN_W-1:0]    a1_win_x,
	input  logic [`BLIT_WIN_W-1:0]    a1_win_y,
	output logic [`BLIT_ADDR_W-1:0]   a1_addr,
	output logic [`BLIT_ADDR_W-1:0]   a2_addr,
	output logic                      a1_outside
);
	import blit_reg_pkg::*;

	// base*8 + (y*width*16 + x) << pixsize, all modulo 2^24
	function automatic logic [`BLIT_ADDR_W-1:0] lin_addr(
		input logic [`BLIT_COORD_W-1:0] x,
		input logic [`BLIT_COORD_W-1:0] y,
		input logic [`BLIT_BASE_W-1:0]  base,
		input logic [`BLIT_FLAGS_W-1:0] flags
	);
		logic [`BLIT_ADDR_W-1:0] line_len;
		logic [`BLIT_ADDR_W-1:0] pix_idx;
		line_len = `BLIT_ADDR_W'({flags[FLAG_WIDTH_HI:FLAG_WIDTH_LO], 4'b0000});
		// Pixel index within the surface
		pix_idx = `BLIT_ADDR_W'(y) * line_len + `BLIT_ADDR_W'(x);
		lin_addr = {base, 3'b000} + (pix_idx << flags[FLAG_PIXSIZE_HI:FLAG_PIXSIZE_LO]);
	endfunction

	assign a1_addr = lin_addr(a1_x, a1_y, a1_base, a1_flags);
	// A2 coordinates arrive masked
	assign a2_addr = lin_addr(a2_x, a2_y, a2_base, a2_flags);

	// Unsigned compare, a negative pointer counts as far outside
	assign a1_outside = (a1_x >= {1'b0, a1_win_x}) || (a1_y >= {1'b0, a1_win_y});

endmodule

// File: address/address_pointer.sv
// A1 and A2 pixel pointers with their increment and step adder
// Integer pointers only, no fractional part
// A2 is stored unmasked and the mask applies at the outputs
// A host load wins over any pointer opcode in the same cycle
`timescale 1ns/1ps
`include "blit_macros.svh"

module address_pointer (
	input  logic                      sys_clk,
	input  logic                      rst,
	input  logic                      a1_ptr_ld,
	input  logic                      a2_ptr_ld,
	input  logic [`BLIT_DATA_W-1:0]   host_din,
	input  blit_seq_pkg::ptr_op_t     ptr_op,
	input  logic [`BLIT_COORD_W-1:0]  a1_inc_x,
	input  logic [`BLIT_COORD_W-1:0]  a1_inc_y,
	input  logic [`BLIT_COORD_W-1:0]  a1_step_x,
	input  logic [`BLIT_COORD_W-1:0]  a1_step_y,
	input  logic [`BLIT_COORD_W-1:0]  a2_step_x,
	input  logic [`BLIT_COORD_W-1:0]  a2_step_y,
	input  logic [`BLIT_FLAGS_W-1:0]  a1_flags,
	input  logic [`BLIT_FLAGS_W-1:0]  a2_flags,
	input  logic [`BLIT_COORD_W-1:0]  a2_mask_x,
	input  logic [`BLIT_COORD_W-1:0]  a2_mask_y,
	output logic [`BLIT_COORD_W-1:0]  a1_x,
	output logic [`BLIT_COORD_W-1:0]  a1_y,
	output logic [`BLIT_COORD_W-1:0]  a2_x,
	output logic [`BLIT_COORD_W-1:0]  a2_y,
	output logic [`BLIT_DATA_W-1:0]   a1_ptr_cur,
	output logic [`BLIT_DATA_W-1:0]   a2_ptr_cur
);
	import blit_reg_pkg::*;
	import blit_seq_pkg::*;

	logic [`BLIT_COORD_W-1:0] a2_xr;
	logic [`BLIT_COORD_W-1:0] a2_yr;
	logic [`BLIT_COORD_W-1:0] a1_add_x;
	logic [`BLIT_COORD_W-1:0] a1_add_y;
	logic [`BLIT_COORD_W-1:0] a2_add_x;
	logic [`BLIT_COORD_W-1:0] a2_add_y;
	logic                     a2_mask_en;

	// Modulo 2^16 add or subtract
	function automatic logic [`BLIT_COORD_W-1:0] add_sign(
		input logic [`BLIT_COORD_W-1:0] a,
		input logic [`BLIT_COORD_W-1:0] b,
		input logic                     sub
	);
		add_sign = sub ? (a - b) : (a + b);
	endfunction

	// Shared addend select
	always_comb begin
		if (ptr_op == OP_STEP) begin
			a1_add_x = a1_step_x;
			a1_add_y = a1_step_y;
			a2_add_x = a2_step_x;
			a2_add_y = a2_step_y;
		end else begin
			a1_add_x = a1_inc_x;
			a1_add_y = a1_inc_y;
			// A2 moves one pixel along x and stays on its line
			a2_add_x = `BLIT_COORD_W'(1);
			a2_add_y = '0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			a1_x  <= '0;
			a1_y  <= '0;
			a2_xr <= '0;
			a2_yr <= '0;
		end else begin
			if (a1_ptr_ld) begin
				a1_x <= host_din[`BLIT_COORD_W-1:0];
				a1_y <= host_din[`BLIT_DATA_W-1:`BLIT_COORD_W];
			end else if (ptr_op != OP_HOLD) begin
				a1_x <= add_sign(a1_x, a1_add_x, a1_flags[FLAG_XSIGN]);
				a1_y <= add_sign(a1_y, a1_add_y, a1_flags[FLAG_YSIGN]);
			end
			if (a2_ptr_ld) begin
				a2_xr <= host_din[`BLIT_COORD_W-1:0];
				a2_yr <= host_din[`BLIT_DATA_W-1:`BLIT_COORD_W];
			end else if (ptr_op != OP_HOLD) begin
				a2_xr <= add_sign(a2_xr, a2_add_x, a2_flags[FLAG_XSIGN]);
				a2_yr <= add_sign(a2_yr, a2_add_y, a2_flags[FLAG_YSIGN]);
			end
		end
	end

	// Masked view feeds both address generation and readback
	assign a2_mask_en = a2_flags[FLAG_MASK_EN];
	assign a2_x = a2_mask_en ? (a2_xr & a2_mask_x) : a2_xr;
	assign a2_y = a2_mask_en ? (a2_yr & a2_mask_y) : a2_yr;

	assign a1_ptr_cur = {a1_y, a1_x};
	assign a2_ptr_cur = {a2_y, a2_x};

endmodule

// File: address/address_regs.sv
// Host register file of the address unit
// Writes land at the load_strobe edge and are dropped while busy
// PTR writes are not stored here and only pulse a1_ptr_ld or a2_ptr_ld
// Readback is combinational and covers the two pointers only
`timescale 1ns/1ps
`include "blit_macros.svh"

module address_regs (
	input  logic                      sys_clk,
	input  logic                      rst,
	input  logic                      load_strobe,
	input  blit_reg_pkg::reg_sel_t    reg_sel,
	input  logic [`BLIT_DATA_W-1:0]   host_din,
	input  logic                      host_rd,
	input  logic                      busy,
	input  logic [`BLIT_DATA_W-1:0]   a1_ptr_cur,
	input  logic [`BLIT_DATA_W-1:0]   a2_ptr_cur,
	output logic [`BLIT_DATA_W-1:0]   host_dout,
	output logic                      dout_oe,
	output logic [`BLIT_BASE_W-1:0]   a1_base,
	output logic [`BLIT_FLAGS_W-1:0]  a1_flags,
	output logic [`BLIT_WIN_W-1:0]    a1_win_x,
	output logic [`BLIT_WIN_W-1:0]    a1_win_y,
	output logic [`BLIT_COORD_W-1:0]  a1_inc_x,
	output logic [`BLIT_COORD_W-1:0]  a1_inc_y,
	output logic [`BLIT_COORD_W-1:0]  a1_step_x,
	output logic [`BLIT_COORD_W-1:0]  a1_step_y,
	output logic [`BLIT_BASE_W-1:0]   a2_base,
	output logic [`BLIT_FLAGS_W-1:0]  a2_flags,
	output logic [`BLIT_COORD_W-1:0]  a2_mask_x,
	output logic [`BLIT_COORD_W-1:0]  a2_mask_y,
	output logic [`BLIT_COORD_W-1:0]  a2_step_x,
	output logic [`BLIT_COORD_W-1:0]  a2_step_y,
	output logic [`BLIT_CNT_W-1:0]    inner_cnt,
	output logic [`BLIT_CNT_W-1:0]    outer_cnt,
	output logic                      a1_ptr_ld,
	output logic                      a2_ptr_ld
);
	import blit_reg_pkg::*;

	logic                     wr_en;
	logic [`BLIT_COORD_W-1:0] din_lo;
	logic [`BLIT_COORD_W-1:0] din_hi;

	// Host writes are locked out for the whole blit
	assign wr_en = load_strobe & ~busy;

	// x or inner count in the low half, y or outer count in the high half
	assign din_lo = host_din[`BLIT_COORD_W-1:0];
	assign din_hi = host_din[`BLIT_DATA_W-1:`BLIT_COORD_W];

	// Pointer registers live in address_pointer and load on these pulses
	assign a1_ptr_ld = wr_en && (reg_sel == REG_A1_PTR);
	assign a2_ptr_ld = wr_en && (reg_sel == REG_A2_PTR);

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			a1_base   <= '0;
			a1_flags  <= '0;
			a1_win_x  <= '0;
			a1_win_y  <= '0;
			a1_inc_x  <= '0;
			a1_inc_y  <= '0;
			a1_step_x <= '0;
			a1_step_y <= '0;
			a2_base   <= '0;
			a2_flags  <= '0;
			a2_mask_x <= '0;
			a2_mask_y <= '0;
			a2_step_x <= '0;
			a2_step_y <= '0;
			inner_cnt <= '0;
			outer_cnt <= '0;
		end else if (wr_en) begin
			case (reg_sel)
				// Base drops the three byte-offset bits
				REG_A1_BASE:  a1_base  <= host_din[`BLIT_BASE_W+2:3];
				REG_A1_FLAGS: a1_flags <= host_din[`BLIT_FLAGS_W-1:0];
				REG_A1_WIN: begin
					// Window y starts at bit 16, bit 31 ignored
					a1_win_x <= host_din[`BLIT_WIN_W-1:0];
					a1_win_y <= din_hi[`BLIT_WIN_W-1:0];
				end
				REG_A1_STEP: begin
					a1_step_x <= din_lo;
					a1_step_y <= din_hi;
				end
				REG_A1_INC: begin
					a1_inc_x <= din_lo;
					a1_inc_y <= din_hi;
				end
				REG_A2_BASE:  a2_base  <= host_din[`BLIT_BASE_W+2:3];
				REG_A2_FLAGS: a2_flags <= host_din[`BLIT_FLAGS_W-1:0];
				REG_A2_MASK: begin
					a2_mask_x <= din_lo;
					a2_mask_y <= din_hi;
				end
				REG_A2_STEP: begin
					a2_step_x <= din_lo;
					a2_step_y <= din_hi;
				end
				REG_COUNT: begin
					inner_cnt <= din_lo;
					outer_cnt <= din_hi;
				end
				// PTR selects and unused codes store nothing here
				default: ;
			endcase
		end
	end

	// Only the pointer selects drive the read bus
	assign dout_oe = host_rd && (reg_sel == REG_A1_PTR || reg_sel == REG_A2_PTR);
	// A2 value arrives already masked
	assign host_dout = (reg_sel == REG_A2_PTR) ? a2_ptr_cur : a1_ptr_cur;

endmodule

// File: common/blit_macros.svh
// Width definitions for the blitter address unit
// Expects common/ on the include path
// BASE counts 8-byte units, so it fills address bits 23:3
`ifndef BLIT_MACROS_SVH
`define BLIT_MACROS_SVH

// Host bus
`define BLIT_DATA_W 32
// Pointer, step, increment and mask coordinates
`define BLIT_COORD_W 16
// Clip window coordinates are one bit narrower than a pointer
`define BLIT_WIN_W 15
// Inner and outer blit counts
`define BLIT_CNT_W 16
// Channel base in 8-byte units
`define BLIT_BASE_W 21
// Channel flag register
`define BLIT_FLAGS_W 21
// Byte address out, wraps modulo 2^24
`define BLIT_ADDR_W 24

`endif

// File: common/blit_reg_pkg.sv
// Register map of the blitter address unit
// Select codes above REG_COUNT are not decoded
// Flag positions hold for both the A1 and the A2 flag register
package blit_reg_pkg;

	// Host register select
	typedef enum logic [3:0] {
		REG_A1_BASE  = 4'd0,
		REG_A1_FLAGS = 4'd1,
		REG_A1_WIN   = 4'd2,
		REG_A1_PTR   = 4'd3,
		REG_A1_STEP  = 4'd4,
		REG_A1_INC   = 4'd5,
		REG_A2_BASE  = 4'd6,
		REG_A2_FLAGS = 4'd7,
		REG_A2_MASK  = 4'd8,
		REG_A2_PTR   = 4'd9,
		REG_A2_STEP  = 4'd10,
		REG_COUNT    = 4'd11
	} reg_sel_t;

	// log2 of bytes per pixel, 0 to 2
	localparam int FLAG_PIXSIZE_LO = 3;
	localparam int FLAG_PIXSIZE_HI = 5;
	// Line length is sixteen pixels per unit
	localparam int FLAG_WIDTH_LO = 9;
	localparam int FLAG_WIDTH_HI = 14;
	// Mask enable, A2 only
	localparam int FLAG_MASK_EN = 15;
	// Set sign bit subtracts
	localparam int FLAG_XSIGN = 19;
	localparam int FLAG_YSIGN = 20;

endpackage

// File: common/blit_seq_pkg.sv
// Sequencer encodings of the blitter address unit
// ptr_op_t value 3 is never issued
package blit_seq_pkg;

	// Blit sequencer states
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_PIXEL = 2'd1,
		ST_STEP  = 2'd2,
		ST_DONE  = 2'd3
	} seq_state_t;

	// Pointer update for the current cycle
	typedef enum logic [1:0] {
		OP_HOLD = 2'd0,
		OP_INC  = 2'd1,
		OP_STEP = 2'd2
	} ptr_op_t;

endpackage

// File: project.f
+incdir+common
common/blit_reg_pkg.sv
common/blit_seq_pkg.sv
address/address_regs.sv
address/address_pointer.sv
address/address_gen.sv
verilog/blit_sequencer.sv
verilog/blit_counter.sv
verilog/blit_addr_top.sv
tests/blit_addr_checker.sv
tests/tb_blit_addr.sv

// File: tests/blit_addr_checker.sv
// Reference model and comparator for the blitter address unit
// Watches the DUT ports only and samples them on the rising edge
// Expects host writes to be ignored while a blit is running
// Counts of zero are modelled as one
`timescale 1ns/1ps
`include "blit_macros.svh"

module blit_addr_checker (
	input  logic                     sys_clk,
	input  logic                     rst,
	input  logic                     load_strobe,
	input  blit_reg_pkg::reg_sel_t   reg_sel,
	input  logic [`BLIT_DATA_W-1:0]  host_din,
	input  logic                     host_rd,
	input  logic                     start,
	input  logic [`BLIT_DATA_W-1:0]  host_dout,
	input  logic                     dout_oe,
	input  logic                     busy,
	input  logic                     done,
	input  logic                     addr_valid,
	input  logic [`BLIT_ADDR_W-1:0]  a1_addr,
	input  logic [`BLIT_ADDR_W-1:0]  a2_addr,
	input  logic                     a1_outside,
	output int                       err_count
);
	import blit_reg_pkg::*;

	// Model sequencer states
	localparam int S_IDLE  = 0;
	localparam int S_PIXEL = 1;
	localparam int S_STEP  = 2;
	localparam int S_DONE  = 3;

	int errors = 0;
	int state;
	int px;
	int ln;
	int cyc;
	int start_cyc;
	int valid_cnt;
	// Register copy built from the snooped host writes
	logic [`BLIT_BASE_W-1:0]  a1_base;
	logic [`BLIT_BASE_W-1:0]  a2_base;
	logic [`BLIT_FLAGS_W-1:0] a1_flags;
	logic [`BLIT_FLAGS_W-1:0] a2_flags;
	logic [`BLIT_WIN_W-1:0]   win_x;
	logic [`BLIT_WIN_W-1:0]   win_y;
	logic [`BLIT_COORD_W-1:0] inc_x;
	logic [`BLIT_COORD_W-1:0] inc_y;
	logic [`BLIT_COORD_W-1:0] a1_stx;
	logic [`BLIT_COORD_W-1:0] a1_sty;
	logic [`BLIT_COORD_W-1:0] a2_stx;
	logic [`BLIT_COORD_W-1:0] a2_sty;
	logic [`BLIT_COORD_W-1:0] mask_x;
	logic [`BLIT_COORD_W-1:0] mask_y;
	logic [`BLIT_COORD_W-1:0] inner;
	logic [`BLIT_COORD_W-1:0] outer;
	// Model pointers, A2 kept unmasked
	logic [`BLIT_COORD_W-1:0] a1x;
	logic [`BLIT_COORD_W-1:0] a1y;
	logic [`BLIT_COORD_W-1:0] a2x;
	logic [`BLIT_COORD_W-1:0] a2y;

	assign err_count = errors;

	function automatic int eff_count(input logic [`BLIT_COORD_W-1:0] c);
		return (c == 0) ? 1 : int'(c);
	endfunction

	// Set sign subtracts, result wraps at 16 bits
	function automatic logic [`BLIT_COORD_W-1:0] move(
		input logic [`BLIT_COORD_W-1:0] p,
		input logic [`BLIT_COORD_W-1:0] d,
		input logic                     neg
	);
		return neg ? p - d : p + d;
	endfunction

	// base*8 + (y*width*16 + x) scaled by pixel size, modulo 2^24
	function automatic logic [`BLIT_ADDR_W-1:0] pixel_addr(
		input logic [`BLIT_COORD_W-1:0] x,
		input logic [`BLIT_COORD_W-1:0] y,
		input logic [`BLIT_BASE_W-1:0]  base,
		input logic [`BLIT_FLAGS_W-1:0] flags
	);
		logic [63:0] line_len;
		logic [63:0] index;
		logic [63:0] full;
		line_len = flags[FLAG_WIDTH_HI:FLAG_WIDTH_LO] * 16;
		index = y * line_len + x;
		full = base * 8 + (index << flags[FLAG_PIXSIZE_HI:FLAG_PIXSIZE_LO]);
		return full[`BLIT_ADDR_W-1:0];
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic report_issue(input string msg);
		$display("%0t %s", $time, msg);
		errors++;
	endtask

	task automatic reset_model();
		state = S_IDLE;
		px = 0;
		ln = 0;
		cyc = 0;
		start_cyc = 0;
		valid_cnt = 0;
		{a1_base, a2_base, a1_flags, a2_flags, win_x, win_y} = '0;
		{inc_x, inc_y, a1_stx, a1_sty, a2_stx, a2_sty} = '0;
		{mask_x, mask_y, inner, outer, a1x, a1y, a2x, a2y} = '0;
	endtask

	task automatic check_outputs();
		logic [`BLIT_COORD_W-1:0] a2mx;
		logic [`BLIT_COORD_W-1:0] a2my;
		logic                     exp_out;
		int                       exp_len;
		a2mx = a2_flags[FLAG_MASK_EN] ? (a2x & mask_x) : a2x;
		a2my = a2_flags[FLAG_MASK_EN] ? (a2y & mask_y) : a2y;
		check_val("busy", state != S_IDLE, busy);
		check_val("done", state == S_DONE, done);
		check_val("addr_valid", state == S_PIXEL, addr_valid);
		if (addr_valid === 1'b1)
			valid_cnt++;
		if (state == S_PIXEL) begin
			check_val("a1_addr", pixel_addr(a1x, a1y, a1_base, a1_flags), a1_addr);
			check_val("a2_addr", pixel_addr(a2mx, a2my, a2_base, a2_flags), a2_addr);
			// Unsigned window compare on plain integer values
			exp_out = (int'(a1x) >= int'(win_x)) || (int'(a1y) >= int'(win_y));
			check_val("a1_outside", exp_out, a1_outside);
		end
		if (host_rd && (reg_sel == REG_A1_PTR || reg_sel == REG_A2_PTR)) begin
			check_val("dout_oe", 1, dout_oe);
			check_val("host_dout", (reg_sel == REG_A1_PTR) ? {a1y, a1x} : {a2my, a2mx},
				host_dout);
		end else begin
			check_val("dout_oe", 0, dout_oe);
		end
		if (cyc == start_cyc + 1 && state == S_PIXEL && addr_valid !== 1'b1)
			report_issue("first address did not come one cycle after start");
		if (done === 1'b1) begin
			exp_len = eff_count(outer) * (eff_count(inner) + 1) + 1;
			if (cyc - start_cyc != exp_len)
				report_issue($sformatf("done came %0d cycles after start, expected %0d",
					cyc - start_cyc, exp_len));
			if (valid_cnt != eff_count(inner) * eff_count(outer))
				report_issue($sformatf("blit gave %0d addresses, expected %0d",
					valid_cnt, eff_count(inner) * eff_count(outer)));
		end
	endtask

	task automatic capture_write();
		case (reg_sel)
			REG_A1_BASE:  a1_base = host_din[23:3];
			REG_A1_FLAGS: a1_flags = host_din[20:0];
			REG_A1_WIN: begin
				win_x = host_din[14:0];
				win_y = host_din[30:16];
			end
			REG_A1_PTR:   {a1y, a1x} = host_din;
			REG_A1_STEP:  {a1_sty, a1_stx} = host_din;
			REG_A1_INC:   {inc_y, inc_x} = host_din;
			REG_A2_BASE:  a2_base = host_din[23:3];
			REG_A2_FLAGS: a2_flags = host_din[20:0];
			REG_A2_MASK:  {mask_y, mask_x} = host_din;
			REG_A2_PTR:   {a2y, a2x} = host_din;
			REG_A2_STEP:  {a2_sty, a2_stx} = host_din;
			REG_COUNT:    {outer, inner} = host_din;
			default: ;
		endcase
	endtask

	task automatic step_model();
		logic idle;
		idle = (state == S_IDLE);
		if (state == S_PIXEL) begin
			a1x = move(a1x, inc_x, a1_flags[FLAG_XSIGN]);
			a1y = move(a1y, inc_y, a1_flags[FLAG_YSIGN]);
			// A2 walks one pixel along x
			a2x = move(a2x, 16'd1, a2_flags[FLAG_XSIGN]);
			if (px == eff_count(inner) - 1) begin
				px = 0;
				state = S_STEP;
			end else begin
				px++;
			end
		end else if (state == S_STEP) begin
			a1x = move(a1x, a1_stx, a1_flags[FLAG_XSIGN]);
			a1y = move(a1y, a1_sty, a1_flags[FLAG_YSIGN]);
			a2x = move(a2x, a2_stx, a2_flags[FLAG_XSIGN]);
			a2y = move(a2y, a2_sty, a2_flags[FLAG_YSIGN]);
			if (ln == eff_count(outer) - 1) begin
				state = S_DONE;
			end else begin
				ln++;
				state = S_PIXEL;
			end
		end else if (state == S_DONE) begin
			state = S_IDLE;
		end else if (start) begin
			state = S_PIXEL;
			px = 0;
			ln = 0;
			start_cyc = cyc;
			valid_cnt = 0;
		end
		// Writes only land while idle
		if (load_strobe && idle)
			capture_write();
	endtask

	always @(posedge sys_clk) begin
		if (rst) begin
			reset_model();
		end else begin
			cyc++;
			check_outputs();
			step_model();
		end
	end

endmodule

// File: tests/tb_blit_addr.sv
// Testbench top for the blitter address unit
// Inputs change on the falling edge, the checker samples on the rising edge
// Blit counts stay within 1 to 8 so the timeout bound holds
`timescale 1ns/1ps
`include "blit_macros.svh"

module tb_blit_addr;
	import blit_reg_pkg::*;

	localparam int N_BLITS        = 20;
	// Longest blit plus start and idle margin
	localparam int BLIT_MAX       = 8 * 9 + 4;
	// Twelve writes of two cycles plus readback
	localparam int SETUP_PER_BLIT = 2 * 12 + 8;
	localparam int TIMEOUT_CYCLES = 2 * ((N_BLITS + 1) * (BLIT_MAX + SETUP_PER_BLIT) + 100);

	logic                     sys_clk = 1'b0;
	logic                     rst;
	logic                     load_strobe;
	reg_sel_t                 reg_sel;
	logic [`BLIT_DATA_W-1:0]  host_din;
	logic                     host_rd;
	logic                     start;
	logic [`BLIT_DATA_W-1:0]  host_dout;
	logic                     dout_oe;
	logic                     busy;
	logic                     done;
	logic                     addr_valid;
	logic [`BLIT_ADDR_W-1:0]  a1_addr;
	logic [`BLIT_ADDR_W-1:0]  a2_addr;
	logic                     a1_outside;
	int                       err_count;
	int                       cycle_cnt = 0;
	int                       tests_run = 0;
	int                       tests_failed = 0;
	int                       errs_at_start;
	logic [31:0]              rng = 32'h6e392365;

	blit_addr_top blit_addr_inst (.*);
	blit_addr_checker checker_inst (.*);

	always #50 sys_clk = ~sys_clk;

	// Hang guard
	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic draw(output logic [31:0] v);
		rng = xorshift32(rng);
		v = rng;
	endtask

	// Pixel size 0 to 2, random width, mask enable and signs
	task automatic make_flags(output logic [31:0] f);
		logic [31:0] r;
		draw(r);
		f = '0;
		f[FLAG_PIXSIZE_HI:FLAG_PIXSIZE_LO] = r[7:0] % 3;
		f[FLAG_WIDTH_HI:FLAG_WIDTH_LO] = r[13:8];
		f[FLAG_MASK_EN] = r[14];
		f[FLAG_XSIGN] = r[19];
		f[FLAG_YSIGN] = r[20];
	endtask

	task automatic write_reg(input reg_sel_t sel, input logic [31:0] data);
		@(negedge sys_clk);
		reg_sel = sel;
		host_din = data;
		load_strobe = 1'b1;
		@(negedge sys_clk);
		load_strobe = 1'b0;
	endtask

	task automatic read_ptr(input reg_sel_t sel);
		@(negedge sys_clk);
		reg_sel = sel;
		host_rd = 1'b1;
		@(negedge sys_clk);
		host_rd = 1'b0;
	endtask

	task automatic pulse_start();
		@(negedge sys_clk);
		start = 1'b1;
		@(negedge sys_clk);
		start = 1'b0;
	endtask

	task automatic wait_done();
		@(negedge sys_clk);
		while (done !== 1'b1)
			@(negedge sys_clk);
	endtask

	task automatic configure_random(input logic long_blit);
		logic [31:0] v;
		logic [31:0] f;
		logic [15:0] n_in;
		logic [15:0] n_out;
		draw(v);
		write_reg(REG_A1_BASE, v);
		make_flags(f);
		write_reg(REG_A1_FLAGS, f);
		draw(v);
		write_reg(REG_A1_WIN, v);
		draw(v);
		write_reg(REG_A1_PTR, v);
		draw(v);
		write_reg(REG_A1_STEP, v);
		draw(v);
		write_reg(REG_A1_INC, v);
		draw(v);
		write_reg(REG_A2_BASE, v);
		make_flags(f);
		write_reg(REG_A2_FLAGS, f);
		draw(v);
		write_reg(REG_A2_MASK, v);
		draw(v);
		write_reg(REG_A2_PTR, v);
		draw(v);
		write_reg(REG_A2_STEP, v);
		draw(v);
		n_in = v[2:0] + 16'd1;
		n_out = v[18:16] + 16'd1;
		if (long_blit)
			write_reg(REG_COUNT, {16'd8, 16'd8});
		else
			write_reg(REG_COUNT, {n_out, n_in});
	endtask

	task automatic begin_test();
		errs_at_start = err_count;
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = err_count - errs_at_start;
		tests_run++;
		if (errs != 0)
			tests_failed++;
		$display("Test %s %s with %0d mismatches", name, (errs == 0) ? "passed" : "failed", errs);
	endtask

	initial begin
		logic [31:0] v;
		logic [31:0] f;
		rst = 1'b1;
		load_strobe = 1'b0;
		reg_sel = REG_A1_BASE;
		host_din = '0;
		host_rd = 1'b0;
		start = 1'b0;
		repeat (3) @(negedge sys_clk);
		rst = 1'b0;

		// Idle outputs and zero pointers
		begin_test();
		read_ptr(REG_A1_PTR);
		read_ptr(REG_A2_PTR);
		end_test("reset");

		// Readback with the A2 mask on and off
		begin_test();
		for (int i = 0; i < 8; i++) begin
			make_flags(f);
			f[FLAG_MASK_EN] = i[0];
			write_reg(REG_A2_FLAGS, f);
			draw(v);
			write_reg(REG_A2_MASK, v);
			draw(v);
			write_reg(REG_A1_PTR, v);
			draw(v);
			write_reg(REG_A2_PTR, v);
			read_ptr(REG_A1_PTR);
			read_ptr(REG_A2_PTR);
		end
		end_test("readback");

		// Addresses, window flag and timing over random blits
		begin_test();
		for (int b = 0; b < N_BLITS; b++) begin
			configure_random(1'b0);
			pulse_start();
			wait_done();
			read_ptr(REG_A1_PTR);
			read_ptr(REG_A2_PTR);
		end
		end_test("blits");

		// Writes during a blit must be dropped
		begin_test();
		configure_random(1'b1);
		pulse_start();
		for (int r = 0; r < 12; r++) begin
			draw(v);
			write_reg(reg_sel_t'(r), v);
		end
		wait_done();
		read_ptr(REG_A1_PTR);
		read_ptr(REG_A2_PTR);
		end_test("busy_writes");

		$display("Tests run %0d, tests failed %0d, mismatches %0d",
			tests_run, tests_failed, err_count);
		if (err_count == 0 && tests_failed == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: verilog/blit_addr_top.sv
// Blitter address unit top level
// Single clock, synchronous active-high reset
// No back-pressure, one address pair per addr_valid cycle
// Submodule ports share names with the nets here
`timescale 1ns/1ps
`include "blit_macros.svh"

module blit_addr_top (
	input  logic                     sys_clk,
	input  logic                     rst,
	input  logic                     load_strobe,
	input  blit_reg_pkg::reg_sel_t   reg_sel,
	input  logic [`BLIT_DATA_W-1:0]  host_din,
	input  logic                     host_rd,
	input  logic                     start,
	output logic [`BLIT_DATA_W-1:0]  host_dout,
	output logic                     dout_oe,
	output logic                     busy,
	output logic                     done,
	output logic                     addr_valid,
	output logic [`BLIT_ADDR_W-1:0]  a1_addr,
	output logic [`BLIT_ADDR_W-1:0]  a2_addr,
	output logic                     a1_outside
);
	import blit_seq_pkg::*;

	// Configuration from the register file
	logic [`BLIT_BASE_W-1:0]  a1_base;
	logic [`BLIT_BASE_W-1:0]  a2_base;
	logic [`BLIT_FLAGS_W-1:0] a1_flags;
	logic [`BLIT_FLAGS_W-1:0] a2_flags;
	logic [`BLIT_WIN_W-1:0]   a1_win_x;
	logic [`BLIT_WIN_W-1:0]   a1_win_y;
	logic [`BLIT_COORD_W-1:0] a1_inc_x;
	logic [`BLIT_COORD_W-1:0] a1_inc_y;
	logic [`BLIT_COORD_W-1:0] a1_step_x;
	logic [`BLIT_COORD_W-1:0] a1_step_y;
	logic [`BLIT_COORD_W-1:0] a2_step_x;
	logic [`BLIT_COORD_W-1:0] a2_step_y;
	logic [`BLIT_COORD_W-1:0] a2_mask_x;
	logic [`BLIT_COORD_W-1:0] a2_mask_y;
	logic [`BLIT_CNT_W-1:0]   inner_cnt;
	logic [`BLIT_CNT_W-1:0]   outer_cnt;
	logic                     a1_ptr_ld;
	logic                     a2_ptr_ld;
	// Pointer state, A2 masked
	logic [`BLIT_DATA_W-1:0]  a1_ptr_cur;
	logic [`BLIT_DATA_W-1:0]  a2_ptr_cur;
	logic [`BLIT_COORD_W-1:0] a1_x;
	logic [`BLIT_COORD_W-1:0] a1_y;
	logic [`BLIT_COORD_W-1:0] a2_x;
	logic [`BLIT_COORD_W-1:0] a2_y;
	// Sequencer and counter handshake
	ptr_op_t                  ptr_op;
	logic                     cnt_load;
	logic                     cnt_pixel;
	logic                     cnt_line;
	logic                     last_pixel;
	logic                     last_line;

	address_regs    regs_inst (.*);
	address_pointer pointer_inst (.*);
	address_gen     gen_inst (.*);
	blit_sequencer  seq_inst (.*);
	blit_counter    counter_inst (.*);

endmodule

// File: verilog/blit_counter.sv
// Inner and outer blit down-counters
// A zero count runs as one
// Inner count reloads from the register at every line step
`timescale 1ns/1ps
`include "blit_macros.svh"

module blit_counter (
	input  logic                    sys_clk,
	input  logic                    rst,
	input  logic                    cnt_load,
	input  logic                    cnt_pixel,
	input  logic                    cnt_line,
	input  logic [`BLIT_CNT_W-1:0]  inner_cnt,
	input  logic [`BLIT_CNT_W-1:0]  outer_cnt,
	output logic                    last_pixel,
	output logic                    last_line
);
	logic [`BLIT_CNT_W-1:0] inner_left;
	logic [`BLIT_CNT_W-1:0] outer_left;
	logic [`BLIT_CNT_W-1:0] inner_eff;
	logic [`BLIT_CNT_W-1:0] outer_eff;

	assign inner_eff = (inner_cnt == '0) ? `BLIT_CNT_W'(1) : inner_cnt;
	assign outer_eff = (outer_cnt == '0) ? `BLIT_CNT_W'(1) : outer_cnt;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			inner_left <= '0;
			outer_left <= '0;
		end else if (cnt_load) begin
			inner_left <= inner_eff;
			outer_left <= outer_eff;
		end else if (cnt_line) begin
			inner_left <= inner_eff;
			outer_left <= outer_left - 1'b1;
		end else if (cnt_pixel) begin
			inner_left <= inner_left - 1'b1;
		end
	end

	// One left means the current pixel or line is the final one
	assign last_pixel = (inner_left == `BLIT_CNT_W'(1));
	assign last_line  = (outer_left == `BLIT_CNT_W'(1));

endmodule

// File: verilog/blit_sequencer.sv
// Blit state machine
// One ST_PIXEL cycle per pixel, one ST_STEP cycle per line
// A start outside ST_IDLE is ignored
`timescale 1ns/1ps

module blit_sequencer (
	input  logic                   sys_clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic                   last_pixel,
	input  logic                   last_line,
	output logic                   busy,
	output logic                   done,
	output logic                   addr_valid,
	output blit_seq_pkg::ptr_op_t  ptr_op,
	output logic                   cnt_load,
	output logic                   cnt_pixel,
	output logic                   cnt_line
);
	import blit_seq_pkg::*;

	seq_state_t state;
	seq_state_t state_nxt;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		ptr_op    = OP_HOLD;
		cnt_load  = 1'b0;
		cnt_pixel = 1'b0;
		cnt_line  = 1'b0;
		case (state)
			ST_IDLE: begin
				// Counts are captured on the start edge
				if (start) begin
					cnt_load  = 1'b1;
					state_nxt = ST_PIXEL;
				end
			end
			ST_PIXEL: begin
				ptr_op    = OP_INC;
				cnt_pixel = 1'b1;
				if (last_pixel) begin
					state_nxt = ST_STEP;
				end
			end
			ST_STEP: begin
				// Line end, add steps and reload the inner count
				ptr_op    = OP_STEP;
				cnt_line  = 1'b1;
				state_nxt = last_line ? ST_DONE : ST_PIXEL;
			end
			ST_DONE: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	// Outputs decode straight from the state register
	assign busy       = (state != ST_IDLE);
	assign done       = (state == ST_DONE);
	assign addr_valid = (state == ST_PIXEL);

endmodule
